// File: filelist.f
src/pcie_rx_pkg.sv
src/bridge_cfg_pkg.sv
src/cpl_wr_if.sv
src/rx_tlp_decoder.sv
src/pending_read_fifo.sv
src/cpl_buffer.sv
src/cpl_reader.sv
src/pcie_rx_bridge.sv
verif/tb_pcie_rx_bridge.sv

// File: run.sh
#!/bin/sh
# build and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_pcie_rx_bridge -f filelist.f
out=$(./obj_dir/Vtb_pcie_rx_bridge)
echo "$out"
echo "$out" | grep -q -F '*** PASSED ***'

// File: src/bridge_cfg_pkg.sv
// Sizes of the bridge itself: Avalon address, BAR window,
// completion buffer and the pending read queue.
package bridge_cfg_pkg;

   localparam int AVL_ADDR_W   = 32;
   localparam int BAR_OFFSET_W = 20;

   // 8 tags of 32 beats each, 512 bytes per tag
   localparam int NUM_TAGS      = 8;
   localparam int SLOTS_PER_TAG = 32;
   localparam int CPL_DEPTH     = 256;
   localparam int CPL_ADDR_W    = 8;
   // {spare, end flag, data}
   localparam int CPL_WORD_W    = 130;
   localparam int TAG_W         = 3;
   localparam int BEAT_CNT_W    = 6;

   // pending read entry is {avalon addr, len, tag, requester id}
   localparam int PNDG_DEPTH       = 16;
   localparam int PNDG_USED_W      = 5;
   localparam int PNDG_W           = 66;
   localparam int PNDG_STALL_LEVEL = 14;

endpackage

// File: src/cpl_buffer.sv
// Completion data RAM, one write port from the decoder and one read
// port for the reader. Read address is registered, read data is not.
`timescale 1ns/1ps

module cpl_buffer (
   input  logic                                  Clk_i,
   cpl_wr_if.buffer                              wr_port_i,
   input  logic [bridge_cfg_pkg::CPL_ADDR_W-1:0] rd_addr_i,
   output logic [bridge_cfg_pkg::CPL_WORD_W-1:0] rd_data_o
);

   logic [bridge_cfg_pkg::CPL_WORD_W-1:0] mem [bridge_cfg_pkg::CPL_DEPTH];
   logic [bridge_cfg_pkg::CPL_ADDR_W-1:0] rd_addr_q;

   always_ff @(posedge Clk_i)
   begin
      if (wr_port_i.wr_en)
         mem[wr_port_i.wr_addr] <= wr_port_i.wr_data;
      rd_addr_q <= rd_addr_i;
   end

   assign rd_data_o = mem[rd_addr_q];

   // a tag is only played out after all of its beats are stored
   a_no_rdw_collision: assert property (@(posedge Clk_i)
      wr_port_i.wr_en |-> wr_port_i.wr_addr != rd_addr_i);

endmodule

// File: src/cpl_reader.sv
// Plays stored completions out as read data. Descriptors queue up in
// arrival order; each one is read out of the buffer one slot per cycle,
// and the end flag of the last word raises the tag release.
`timescale 1ns/1ps

module cpl_reader (
   input  logic                                  Clk_i,
   input  logic                                  Rstn_i,
   cpl_wr_if.reader                              desc_i,
   output logic [bridge_cfg_pkg::CPL_ADDR_W-1:0] rd_addr_o,
   input  logic [bridge_cfg_pkg::CPL_WORD_W-1:0] rd_data_i,
   output logic [pcie_rx_pkg::DATA_W-1:0]        TxReadData_o,
   output logic                                  TxReadDataValid_o,
   output logic                                  CplTagRelease_o
);

   logic [bridge_cfg_pkg::TAG_W-1:0]      q_tag   [bridge_cfg_pkg::NUM_TAGS];
   logic [bridge_cfg_pkg::BEAT_CNT_W-1:0] q_beats [bridge_cfg_pkg::NUM_TAGS];
   logic [bridge_cfg_pkg::TAG_W-1:0]      q_wr_ptr;
   logic [bridge_cfg_pkg::TAG_W-1:0]      q_rd_ptr;
   logic [bridge_cfg_pkg::TAG_W:0]        q_count;
   logic                                  active_q;
   logic                                  last_slot;
   logic                                  load;
   logic                                  valid_q;
   logic [bridge_cfg_pkg::TAG_W-1:0]      cur_tag_q;
   logic [bridge_cfg_pkg::BEAT_CNT_W-1:0] cur_beats_q;
   logic [bridge_cfg_pkg::BEAT_CNT_W-1:0] slot_q;

   assign last_slot = active_q && ((slot_q + 1'b1) == cur_beats_q);
   // next descriptor starts right behind the last slot of the current one
   assign load      = (q_count != '0) && (!active_q || last_slot);

   always_ff @(posedge Clk_i or negedge Rstn_i)
   begin
      if (!Rstn_i)
      begin
         q_wr_ptr <= '0;
         q_rd_ptr <= '0;
         q_count  <= '0;
         active_q <= 1'b0;
         slot_q   <= '0;
         valid_q  <= 1'b0;
      end
      else
      begin
         if (desc_i.desc_valid)
            q_wr_ptr <= q_wr_ptr + 1'b1;
         if (load)
            q_rd_ptr <= q_rd_ptr + 1'b1;
         q_count <= q_count + (bridge_cfg_pkg::TAG_W+1)'(desc_i.desc_valid)
                            - (bridge_cfg_pkg::TAG_W+1)'(load);
         if (load)
         begin
            active_q <= 1'b1;
            slot_q   <= '0;
         end
         else if (last_slot)
            active_q <= 1'b0;
         else if (active_q)
            slot_q <= slot_q + 1'b1;
         // RAM data trails the address by one cycle
         valid_q <= active_q;
      end
   end

   always_ff @(posedge Clk_i)
   begin
      if (desc_i.desc_valid)
      begin
         q_tag[q_wr_ptr]   <= desc_i.desc_tag;
         q_beats[q_wr_ptr] <= desc_i.desc_beats;
      end
      if (load)
      begin
         cur_tag_q   <= q_tag[q_rd_ptr];
         cur_beats_q <= q_beats[q_rd_ptr];
      end
   end

   assign rd_addr_o = {cur_tag_q,
                       slot_q[bridge_cfg_pkg::CPL_ADDR_W-bridge_cfg_pkg::TAG_W-1:0]};

   assign TxReadData_o      = rd_data_i[pcie_rx_pkg::DATA_W-1:0];
   assign TxReadDataValid_o = valid_q;
   assign CplTagRelease_o   = valid_q & rd_data_i[pcie_rx_pkg::DATA_W];

   a_desc_no_overflow: assert property (@(posedge Clk_i) disable iff (!Rstn_i)
      desc_i.desc_valid && !load |-> q_count < bridge_cfg_pkg::NUM_TAGS);

endmodule

// File: src/cpl_wr_if.sv
// Completion traffic from the decoder: buffer writes, one per data
// beat, and a descriptor pulse once a tag's data is all stored.
`timescale 1ns/1ps

interface cpl_wr_if;
   logic                                  wr_en;
   logic [bridge_cfg_pkg::CPL_ADDR_W-1:0] wr_addr;
   logic [bridge_cfg_pkg::CPL_WORD_W-1:0] wr_data;
   logic                                  desc_valid;
   logic [bridge_cfg_pkg::TAG_W-1:0]      desc_tag;
   logic [bridge_cfg_pkg::BEAT_CNT_W-1:0] desc_beats;

   modport decoder (output wr_en, wr_addr, wr_data, desc_valid, desc_tag, desc_beats);
   modport buffer  (input wr_en, wr_addr, wr_data);
   modport reader  (input desc_valid, desc_tag, desc_beats);
endinterface

// File: src/pcie_rx_bridge.sv
// Receive side of the PCI Express to Avalon bridge. Memory writes go out
// on the Avalon write master, memory reads wait in the pending read
// queue for the transmit side, completions come back as read data.
`timescale 1ns/1ps

module pcie_rx_bridge (
   input  logic                                  Clk_i,
   input  logic                                  Rstn_i,
   input  logic [pcie_rx_pkg::DATA_W-1:0]        RxStData_i,
   input  logic [pcie_rx_pkg::BE_W-1:0]          RxStBe_i,
   input  logic                                  RxStSop_i,
   input  logic                                  RxStEop_i,
   input  logic                                  RxStValid_i,
   input  logic [1:0]                            RxStBarDec_i,
   output logic                                  RxStReady_o,
   input  logic [bridge_cfg_pkg::AVL_ADDR_W-1:0] AvlBarBase0_i,
   input  logic [bridge_cfg_pkg::AVL_ADDR_W-1:0] AvlBarBase1_i,
   output logic                                  RxmWrite_o,
   output logic [bridge_cfg_pkg::AVL_ADDR_W-1:0] RxmAddress_o,
   output logic [pcie_rx_pkg::DATA_W-1:0]        RxmWriteData_o,
   output logic [pcie_rx_pkg::BE_W-1:0]          RxmByteEnable_o,
   input  logic                                  RxmWaitRequest_i,
   input  logic                                  RxPndgRdFifoRdReq_i,
   output logic [bridge_cfg_pkg::PNDG_W-1:0]     RxPndgRdFifoDat_o,
   output logic                                  RxPndgRdFifoEmpty_o,
   output logic [pcie_rx_pkg::DATA_W-1:0]        TxReadData_o,
   output logic                                  TxReadDataValid_o,
   output logic                                  CplTagRelease_o
);

   logic [bridge_cfg_pkg::PNDG_USED_W-1:0] pndg_used;
   logic                                   pndg_wr;
   logic [bridge_cfg_pkg::PNDG_W-1:0]      pndg_entry;
   logic [bridge_cfg_pkg::CPL_ADDR_W-1:0]  cpl_rd_addr;
   logic [bridge_cfg_pkg::CPL_WORD_W-1:0]  cpl_rd_data;

   cpl_wr_if cpl_bus ();

   rx_tlp_decoder u_decoder (
      .Clk_i            (Clk_i),
      .Rstn_i           (Rstn_i),
      .RxStData_i       (RxStData_i),
      .RxStBe_i         (RxStBe_i),
      .RxStSop_i        (RxStSop_i),
      .RxStEop_i        (RxStEop_i),
      .RxStValid_i      (RxStValid_i),
      .RxStBarDec_i     (RxStBarDec_i),
      .RxStReady_o      (RxStReady_o),
      .AvlBarBase0_i    (AvlBarBase0_i),
      .AvlBarBase1_i    (AvlBarBase1_i),
      .RxmWrite_o       (RxmWrite_o),
      .RxmAddress_o     (RxmAddress_o),
      .RxmWriteData_o   (RxmWriteData_o),
      .RxmByteEnable_o  (RxmByteEnable_o),
      .RxmWaitRequest_i (RxmWaitRequest_i),
      .pndg_used_i      (pndg_used),
      .pndg_wr_o        (pndg_wr),
      .pndg_entry_o     (pndg_entry),
      .cpl_o            (cpl_bus.decoder)
   );

   pending_read_fifo u_pndg_fifo (
      .Clk_i   (Clk_i),
      .Rstn_i  (Rstn_i),
      .wr_i    (pndg_wr),
      .entry_i (pndg_entry),
      .rd_i    (RxPndgRdFifoRdReq_i),
      .used_o  (pndg_used),
      .empty_o (RxPndgRdFifoEmpty_o),
      .data_o  (RxPndgRdFifoDat_o)
   );

   cpl_buffer u_cpl_buffer (
      .Clk_i     (Clk_i),
      .wr_port_i (cpl_bus.buffer),
      .rd_addr_i (cpl_rd_addr),
      .rd_data_o (cpl_rd_data)
   );

   cpl_reader u_cpl_reader (
      .Clk_i             (Clk_i),
      .Rstn_i            (Rstn_i),
      .desc_i            (cpl_bus.reader),
      .rd_addr_o         (cpl_rd_addr),
      .rd_data_i         (cpl_rd_data),
      .TxReadData_o      (TxReadData_o),
      .TxReadDataValid_o (TxReadDataValid_o),
      .CplTagRelease_o   (CplTagRelease_o)
   );

endmodule

// File: src/pcie_rx_pkg.sv
// Packet formats seen on the receive stream of the bridge.
// Holds the beat sizes, the type codes and the header union that the
// decoder lays over the first beat of every packet.
package pcie_rx_pkg;

   localparam int DATA_W = 128;
   localparam int BE_W   = 16;

   // type codes, found in the top byte of the start beat
   localparam logic [7:0] FMT_MWR  = 8'h40;
   localparam logic [7:0] FMT_MRD  = 8'h00;
   localparam logic [7:0] FMT_CPLD = 8'h4A;

   // memory read and write requests
   typedef struct packed {
      logic [7:0]  fmt;
      logic [9:0]  len;
      logic [7:0]  tag;
      logic [15:0] req_id;
      logic [31:0] addr;
      logic [53:0] rsvd;
   } req_hdr_t;

   // completions with data
   // beats counts whole 128-bit data beats
   typedef struct packed {
      logic [7:0]   fmt;
      logic [5:0]   beats;
      logic [7:0]   tag;
      logic [105:0] rsvd;
   } cpl_hdr_t;

   // fmt sits in the same bits in both views
   typedef union packed {
      req_hdr_t req;
      cpl_hdr_t cpl;
   } rx_hdr_u;

endpackage

// File: src/pending_read_fifo.sv
// Queue of translated memory read requests, drained by the transmit
// side. No show-ahead: a pop shows its entry from the next cycle.
`timescale 1ns/1ps

module pending_read_fifo (
   input  logic                                   Clk_i,
   input  logic                                   Rstn_i,
   input  logic                                   wr_i,
   input  logic [bridge_cfg_pkg::PNDG_W-1:0]      entry_i,
   input  logic                                   rd_i,
   output logic [bridge_cfg_pkg::PNDG_USED_W-1:0] used_o,
   output logic                                   empty_o,
   output logic [bridge_cfg_pkg::PNDG_W-1:0]      data_o
);

   logic [bridge_cfg_pkg::PNDG_W-1:0]        mem [bridge_cfg_pkg::PNDG_DEPTH];
   logic [bridge_cfg_pkg::PNDG_USED_W-2:0]   wr_ptr_q;
   logic [bridge_cfg_pkg::PNDG_USED_W-2:0]   rd_ptr_q;
   logic [bridge_cfg_pkg::PNDG_USED_W-1:0]   used_q;
   logic [bridge_cfg_pkg::PNDG_W-1:0]        data_q;

   always_ff @(posedge Clk_i or negedge Rstn_i)
   begin
      if (!Rstn_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         used_q   <= '0;
      end
      else
      begin
         if (wr_i)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (rd_i)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         used_q <= used_q + bridge_cfg_pkg::PNDG_USED_W'(wr_i)
                          - bridge_cfg_pkg::PNDG_USED_W'(rd_i);
      end
   end

   always_ff @(posedge Clk_i)
   begin
      if (wr_i)
         mem[wr_ptr_q] <= entry_i;
      if (rd_i)
         data_q <= mem[rd_ptr_q];
   end

   assign used_o  = used_q;
   assign empty_o = (used_q == '0);
   assign data_o  = data_q;

   a_no_overflow: assert property (@(posedge Clk_i) disable iff (!Rstn_i)
      wr_i |-> used_q != bridge_cfg_pkg::PNDG_DEPTH);
   a_no_underflow: assert property (@(posedge Clk_i) disable iff (!Rstn_i)
      rd_i |-> !empty_o);

endmodule

// File: src/rx_tlp_decoder.sv
// Receive side packet decoder. Accepts stream beats, decodes the start
// beat, translates request addresses through BAR0 or BAR1, drives the
// Avalon write master, pushes reads to the pending queue and stores
// completion data per tag.
`timescale 1ns/1ps

module rx_tlp_decoder (
   input  logic                                     Clk_i,
   input  logic                                     Rstn_i,
   input  logic [pcie_rx_pkg::DATA_W-1:0]           RxStData_i,
   input  logic [pcie_rx_pkg::BE_W-1:0]             RxStBe_i,
   input  logic                                     RxStSop_i,
   input  logic                                     RxStEop_i,
   input  logic                                     RxStValid_i,
   input  logic [1:0]                               RxStBarDec_i,
   output logic                                     RxStReady_o,
   input  logic [bridge_cfg_pkg::AVL_ADDR_W-1:0]    AvlBarBase0_i,
   input  logic [bridge_cfg_pkg::AVL_ADDR_W-1:0]    AvlBarBase1_i,
   output logic                                     RxmWrite_o,
   output logic [bridge_cfg_pkg::AVL_ADDR_W-1:0]    RxmAddress_o,
   output logic [pcie_rx_pkg::DATA_W-1:0]           RxmWriteData_o,
   output logic [pcie_rx_pkg::BE_W-1:0]             RxmByteEnable_o,
   input  logic                                     RxmWaitRequest_i,
   input  logic [bridge_cfg_pkg::PNDG_USED_W-1:0]   pndg_used_i,
   output logic                                     pndg_wr_o,
   output logic [bridge_cfg_pkg::PNDG_W-1:0]        pndg_entry_o,
   cpl_wr_if.decoder                                cpl_o
);

   pcie_rx_pkg::rx_hdr_u                     hdr;
   logic                                     accept;
   logic                                     sop_acc;
   logic                                     is_mwr;
   logic                                     is_mrd;
   logic                                     is_cpld;
   logic                                     st_wr_data_q;
   logic                                     st_cpl_q;
   logic                                     rxm_write_q;
   logic                                     write_next;
   logic                                     ready_q;
   logic                                     desc_valid_q;
   logic                                     cpl_last;
   logic [bridge_cfg_pkg::AVL_ADDR_W-1:0]    bar_base;
   logic [bridge_cfg_pkg::AVL_ADDR_W-1:0]    avl_addr;
   logic [bridge_cfg_pkg::AVL_ADDR_W-1:0]    rxm_addr_q;
   logic [pcie_rx_pkg::DATA_W-1:0]           rxm_data_q;
   logic [pcie_rx_pkg::BE_W-1:0]             rxm_be_q;
   logic [bridge_cfg_pkg::TAG_W-1:0]         cpl_tag_q;
   logic [bridge_cfg_pkg::BEAT_CNT_W-1:0]    cpl_beats_q;
   logic [bridge_cfg_pkg::BEAT_CNT_W-1:0]    beat_idx_q;
   logic [bridge_cfg_pkg::PNDG_USED_W-1:0]   used_next;

   assign hdr     = RxStData_i;
   assign accept  = RxStValid_i & ready_q;
   // start beats only count in idle
   assign sop_acc = accept & RxStSop_i & ~st_wr_data_q & ~st_cpl_q;
   assign is_mwr  = (hdr.req.fmt == pcie_rx_pkg::FMT_MWR);
   assign is_mrd  = (hdr.req.fmt == pcie_rx_pkg::FMT_MRD);
   assign is_cpld = (hdr.req.fmt == pcie_rx_pkg::FMT_CPLD);

   // BAR translation keeps the low offset bits of the packet address
   assign bar_base = RxStBarDec_i[0] ? AvlBarBase0_i : AvlBarBase1_i;
   assign avl_addr = bar_base
                   + bridge_cfg_pkg::AVL_ADDR_W'(hdr.req.addr[bridge_cfg_pkg::BAR_OFFSET_W-1:0]);

   assign pndg_wr_o    = sop_acc & is_mrd;
   assign pndg_entry_o = {avl_addr, hdr.req.len, hdr.req.tag, hdr.req.req_id};

   assign cpl_last = (beat_idx_q + bridge_cfg_pkg::BEAT_CNT_W'(1)) == cpl_beats_q;

   // stall while a write is held or the read queue is nearly full
   assign write_next = (rxm_write_q & RxmWaitRequest_i) | (accept & st_wr_data_q);
   assign used_next  = pndg_used_i + bridge_cfg_pkg::PNDG_USED_W'(pndg_wr_o);

   always_ff @(posedge Clk_i or negedge Rstn_i)
   begin
      if (!Rstn_i)
      begin
         st_wr_data_q <= 1'b0;
         st_cpl_q     <= 1'b0;
         rxm_write_q  <= 1'b0;
         ready_q      <= 1'b1;
         desc_valid_q <= 1'b0;
         beat_idx_q   <= '0;
      end
      else
      begin
         ready_q      <= ~write_next & (used_next < bridge_cfg_pkg::PNDG_STALL_LEVEL);
         rxm_write_q  <= write_next;
         desc_valid_q <= accept & st_cpl_q & cpl_last;
         if (sop_acc && is_mwr)
            st_wr_data_q <= 1'b1;
         else if (accept && st_wr_data_q)
            st_wr_data_q <= 1'b0;
         if (sop_acc && is_cpld)
         begin
            st_cpl_q   <= 1'b1;
            beat_idx_q <= '0;
         end
         else if (accept && st_cpl_q)
         begin
            st_cpl_q   <= ~cpl_last;
            beat_idx_q <= beat_idx_q + bridge_cfg_pkg::BEAT_CNT_W'(1);
         end
      end
   end

   always_ff @(posedge Clk_i)
   begin
      if (sop_acc && is_mwr)
         rxm_addr_q <= avl_addr;
      if (accept && st_wr_data_q)
      begin
         rxm_data_q <= RxStData_i;
         rxm_be_q   <= RxStBe_i;
      end
      if (sop_acc && is_cpld)
      begin
         cpl_tag_q   <= hdr.cpl.tag[bridge_cfg_pkg::TAG_W-1:0];
         cpl_beats_q <= hdr.cpl.beats;
      end
   end

   assign RxStReady_o     = ready_q;
   assign RxmWrite_o      = rxm_write_q;
   assign RxmAddress_o    = rxm_addr_q;
   assign RxmWriteData_o  = rxm_data_q;
   assign RxmByteEnable_o = rxm_be_q;

   // beat k of a tag lands in slot tag*32 + k
   assign cpl_o.wr_en      = accept & st_cpl_q;
   assign cpl_o.wr_addr    = {cpl_tag_q,
                              beat_idx_q[bridge_cfg_pkg::CPL_ADDR_W-bridge_cfg_pkg::TAG_W-1:0]};
   assign cpl_o.wr_data    = {1'b0, cpl_last, RxStData_i};
   assign cpl_o.desc_valid = desc_valid_q;
   assign cpl_o.desc_tag   = cpl_tag_q;
   assign cpl_o.desc_beats = cpl_beats_q;

   a_bar_onehot: assert property (@(posedge Clk_i) disable iff (!Rstn_i)
      sop_acc && (is_mwr || is_mrd) |-> $onehot(RxStBarDec_i));

   // the last data beat must carry eop, and no new packet may start mid-packet
   a_no_sop_in_data: assert property (@(posedge Clk_i) disable iff (!Rstn_i)
      accept && (st_wr_data_q || st_cpl_q) |-> !RxStSop_i
         && (RxStEop_i == (st_wr_data_q || cpl_last)));

endmodule

// File: verif/tb_pcie_rx_bridge.sv
// Directed testbench for the PCI Express receive bridge.
// Drives the receive stream on the falling clock edge and runs one task per
// behavior: reset values, memory writes, memory reads, read back-pressure,
// completions and dropped packet types. A monitor on the falling edge counts
// Avalon writes and checks the played-out read data against a queue.
`timescale 1ns/1ps

module tb_pcie_rx_bridge;

   localparam logic [7:0]  TYPE_MWR  = 8'h40;
   localparam logic [7:0]  TYPE_MRD  = 8'h00;
   localparam logic [7:0]  TYPE_CPLD = 8'h4A;
   localparam logic [7:0]  TYPE_BAD  = 8'h7F;
   localparam logic [31:0] BASE0     = 32'h4000_0000;
   localparam logic [31:0] BASE1     = 32'h8010_0000;
   // the whole run needs a few hundred cycles, so this leaves ample margin
   localparam int          WATCHDOG_CYCLES = 4000;

   logic         clk;
   logic         rstn;
   logic [127:0] st_data;
   logic [15:0]  st_be;
   logic         st_sop;
   logic         st_eop;
   logic         st_valid;
   logic [1:0]   bar_dec;
   logic         st_ready;
   logic         rxm_write;
   logic [31:0]  rxm_addr;
   logic [127:0] rxm_data;
   logic [15:0]  rxm_be;
   logic         wait_req;
   logic         rd_req;
   logic [65:0]  pndg_dat;
   logic         pndg_empty;
   logic [127:0] tx_data;
   logic         tx_valid;
   logic         tag_release;

   logic [31:0]  lcg_state = 32'd26177;
   logic [127:0] exp_data [$];
   bit           exp_last [$];
   logic [65:0]  exp_pndg [$];
   int           value_errs = 0;
   int           other_errs = 0;
   int           write_count = 0;
   int           rd_beats = 0;
   int           releases = 0;
   logic         write_prev = 1'b0;

   pcie_rx_bridge dut (
      .Clk_i               (clk),
      .Rstn_i              (rstn),
      .RxStData_i          (st_data),
      .RxStBe_i            (st_be),
      .RxStSop_i           (st_sop),
      .RxStEop_i           (st_eop),
      .RxStValid_i         (st_valid),
      .RxStBarDec_i        (bar_dec),
      .RxStReady_o         (st_ready),
      .AvlBarBase0_i       (BASE0),
      .AvlBarBase1_i       (BASE1),
      .RxmWrite_o          (rxm_write),
      .RxmAddress_o        (rxm_addr),
      .RxmWriteData_o      (rxm_data),
      .RxmByteEnable_o     (rxm_be),
      .RxmWaitRequest_i    (wait_req),
      .RxPndgRdFifoRdReq_i (rd_req),
      .RxPndgRdFifoDat_o   (pndg_dat),
      .RxPndgRdFifoEmpty_o (pndg_empty),
      .TxReadData_o        (tx_data),
      .TxReadDataValid_o   (tx_valid),
      .CplTagRelease_o     (tag_release)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // request header laid out from the top bit down
   function automatic logic [127:0] req_header(input logic [7:0] fmt, input logic [9:0] len,
                                               input logic [7:0] tag, input logic [15:0] rid,
                                               input logic [31:0] addr);
      return {fmt, len, tag, rid, addr, 54'd0};
   endfunction

   function automatic logic [31:0] bar_translate(input logic bar1, input logic [31:0] addr);
      return (bar1 ? BASE1 : BASE0) + {12'd0, addr[19:0]};
   endfunction

   task automatic check_value(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
      assert (got === exp)
      else
      begin
         $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
         value_errs++;
      end
   endtask

   task automatic check_true(input bit cond, input string what);
      assert (cond)
      else
      begin
         $display("%s", what);
         other_errs++;
      end
   endtask

   // offer one beat once ready is high, return on the next falling edge
   task automatic send_beat(input logic [127:0] data, input logic [15:0] be,
                            input logic sop, input logic eop);
      while (!st_ready)
         @(negedge clk);
      st_data  = data;
      st_be    = be;
      st_sop   = sop;
      st_eop   = eop;
      st_valid = 1'b1;
      @(negedge clk);
      st_valid = 1'b0;
      st_sop   = 1'b0;
      st_eop   = 1'b0;
   endtask

   // write count, read data order and release pulses
   always @(negedge clk)
   begin
      if (rstn)
      begin
         if (tx_valid)
         begin
            rd_beats++;
            if (exp_data.size() == 0)
               check_true(1'b0, "read data appeared with no completion data pending");
            else
            begin
               check_value("TxReadData_o", tx_data, exp_data.pop_front());
               check_value("CplTagRelease_o", tag_release, exp_last.pop_front());
            end
            if (tag_release)
               releases++;
         end
         else
            check_true(!tag_release, "tag release pulsed without read data");
         if (rxm_write && !write_prev)
            write_count++;
         write_prev = rxm_write;
      end
   end

   task automatic reset_state();
      check_value("RxmWrite_o", rxm_write, 0);
      check_value("TxReadDataValid_o", tx_valid, 0);
      check_value("CplTagRelease_o", tag_release, 0);
      check_value("RxPndgRdFifoEmpty_o", pndg_empty, 1);
      check_value("RxStReady_o", st_ready, 1);
   endtask

   task automatic mem_write(input logic bar1, input logic [31:0] addr, input int wait_cycles);
      logic [127:0] data;
      logic [31:0]  tmp;
      logic [31:0]  exp_addr;
      int           writes_before;
      data          = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
      tmp           = lcg_next();
      exp_addr      = bar_translate(bar1, addr);
      writes_before = write_count;
      bar_dec       = bar1 ? 2'b10 : 2'b01;
      wait_req      = (wait_cycles > 0);
      send_beat(req_header(TYPE_MWR, 10'd4, tmp[23:16], 16'h0100, addr), 16'hffff, 1'b1, 1'b0);
      send_beat(data, tmp[15:0], 1'b0, 1'b1);
      // write stays up with its fields held while wait request is high
      for (int i = 0; i <= wait_cycles; i++)
      begin
         check_true(rxm_write, "Avalon write not held high while pending");
         check_value("RxmAddress_o", rxm_addr, exp_addr);
         check_value("RxmWriteData_o", rxm_data, data);
         check_value("RxmByteEnable_o", rxm_be, tmp[15:0]);
         if (i == wait_cycles)
            wait_req = 1'b0;
         @(negedge clk);
      end
      check_true(!rxm_write, "Avalon write still high after wait request fell");
      @(negedge clk);
      check_true(write_count == writes_before + 1, "not exactly one Avalon write for a packet");
   endtask

   task automatic mem_read(input logic bar1);
      logic [31:0] addr;
      logic [31:0] tmp;
      addr    = lcg_next();
      tmp     = lcg_next();
      bar_dec = bar1 ? 2'b10 : 2'b01;
      exp_pndg.push_back({bar_translate(bar1, addr), tmp[25:16], tmp[7:0], tmp[31:16]});
      send_beat(req_header(TYPE_MRD, tmp[25:16], tmp[7:0], tmp[31:16], addr),
                16'h0000, 1'b1, 1'b1);
   endtask

   task automatic pop_entry();
      check_true(!pndg_empty, "pending read FIFO empty before a pop");
      rd_req = 1'b1;
      @(negedge clk);
      rd_req = 1'b0;
      if (exp_pndg.size() == 0)
         check_true(1'b0, "pending read popped with no entry expected");
      else
         check_value("RxPndgRdFifoDat_o", pndg_dat, exp_pndg.pop_front());
   endtask

   task automatic mem_reads();
      for (int i = 0; i < 5; i++)
         mem_read(i[0]);
      check_true(!pndg_empty, "pending read FIFO still empty after reads");
      for (int i = 0; i < 5; i++)
         pop_entry();
      check_value("RxPndgRdFifoEmpty_o", pndg_empty, 1);
   endtask

   task automatic read_backpressure();
      for (int i = 0; i < 14; i++)
         mem_read(i[1]);
      for (int i = 0; i < 3; i++)
      begin
         check_value("RxStReady_o", st_ready, 0);
         @(negedge clk);
      end
      for (int i = 0; i < 14; i++)
         pop_entry();
      check_value("RxPndgRdFifoEmpty_o", pndg_empty, 1);
      check_value("RxStReady_o", st_ready, 1);
   endtask

   task automatic completion(input logic [7:0] tag, input int beats);
      logic [127:0] data;
      send_beat({TYPE_CPLD, 6'(beats), tag, 106'd0}, 16'h0000, 1'b1, 1'b0);
      for (int k = 0; k < beats; k++)
      begin
         data = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
         exp_data.push_back(data);
         exp_last.push_back(k == beats - 1);
         send_beat(data, 16'hffff, 1'b0, k == beats - 1);
      end
   endtask

   task automatic completions_in_order();
      int rel_before;
      int beats_before;
      int cycles;
      rel_before   = releases;
      beats_before = rd_beats;
      completion(8'd2, 4);
      completion(8'd5, 1);
      completion(8'd0, 32);
      cycles = 0;
      while (releases < rel_before + 3 && cycles < 200)
      begin
         @(negedge clk);
         cycles++;
      end
      check_true(releases == rel_before + 3, "did not see three tag release pulses");
      check_true(rd_beats == beats_before + 37, "read data beat count is not 37");
      check_true(exp_data.size() == 0, "completion data missing from read data");
   endtask

   task automatic dropped_types();
      int writes_before;
      int beats_before;
      int rel_before;
      writes_before = write_count;
      beats_before  = rd_beats;
      rel_before    = releases;
      bar_dec       = 2'b01;
      // one data beat follows the header
      // a length of 16 dwords reads as one beat in the completion view
      send_beat(req_header(TYPE_BAD, 10'd16, 8'h33, 16'h0200, 32'h0000_1000),
                16'hffff, 1'b1, 1'b0);
      send_beat({lcg_next(), lcg_next(), lcg_next(), lcg_next()}, 16'hffff, 1'b0, 1'b1);
      repeat (10) @(negedge clk);
      check_true(write_count == writes_before, "Avalon write after a dropped packet");
      check_true(rd_beats == beats_before, "read data after a dropped packet");
      check_true(releases == rel_before, "tag release after a dropped packet");
      check_value("RxPndgRdFifoEmpty_o", pndg_empty, 1);
   endtask

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("watchdog expired before the tests finished");
      $display("*** FAILED ***");
      $finish;
   end

   initial
   begin
      rstn     = 1'b0;
      st_data  = '0;
      st_be    = '0;
      st_sop   = 1'b0;
      st_eop   = 1'b0;
      st_valid = 1'b0;
      bar_dec  = 2'b01;
      wait_req = 1'b0;
      rd_req   = 1'b0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;
      @(negedge clk);
      reset_state();
      mem_write(1'b0, 32'hABC1_2340, 0);
      mem_write(1'b1, 32'h0007_FFF0, 3);
      mem_reads();
      read_backpressure();
      completions_in_order();
      dropped_types();
      $display("errors: %0d value, %0d other", value_errs, other_errs);
      if (value_errs == 0 && other_errs == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule
